//--- Makefile
SIM        = verilator
TOP        = tb_mac_loopback
RTL_TOP    = mac_loopback
FILELIST   = mac_loopback.f
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard hdl/*.sv hdl/*.svh verification/*.sv)
	$(SIM) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hdl/mac_loopback.sv
`timescale 1ns/10ps

module mac_loopback
   import xgmac_pkg::*;
(
   input  logic     rx_clk,
   input  logic     arst_n,
   input  rx_beat_t rx_beat,
   input  logic     rx_tvalid,
   output logic     rx_tready,
   output tx_beat_t tx_beat,
   output logic     tx_tvalid,
   input  logic     tx_tready,
   input  reg_req_t reg_req,
   output reg_rsp_t reg_rsp
);

   logic      swap_en;      // Control bit to swapper
   logic      stat_clear;
   stat_cnt_t rx_good;
   stat_cnt_t rx_bad;
   stat_cnt_t tx_frames;
   stat_cnt_t rx_bytes;

   // Stream path, receive back out to transmit
   xgmac_address_swap u_address_swap (
      .rx_clk    (rx_clk),
      .arst_n    (arst_n),
      .swap_en   (swap_en),
      .rx_beat   (rx_beat),
      .rx_tvalid (rx_tvalid),
      .rx_tready (rx_tready),
      .tx_beat   (tx_beat),
      .tx_tvalid (tx_tvalid),
      .tx_tready (tx_tready)
   );

   // Snoops both handshakes
   xgmac_frame_stats u_frame_stats (
      .rx_clk     (rx_clk),
      .arst_n     (arst_n),
      .rx_beat    (rx_beat),
      .rx_tvalid  (rx_tvalid),
      .rx_tready  (rx_tready),
      .tx_beat    (tx_beat),
      .tx_tvalid  (tx_tvalid),
      .tx_tready  (tx_tready),
      .stat_clear (stat_clear),
      .rx_good    (rx_good),
      .rx_bad     (rx_bad),
      .tx_frames  (tx_frames),
      .rx_bytes   (rx_bytes)
   );

   xgmac_reg_bank u_reg_bank (
      .rx_clk     (rx_clk),
      .arst_n     (arst_n),
      .reg_req    (reg_req),
      .reg_rsp    (reg_rsp),
      .swap_en    (swap_en),
      .stat_clear (stat_clear),
      .rx_good    (rx_good),
      .rx_bad     (rx_bad),
      .tx_frames  (tx_frames),
      .rx_bytes   (rx_bytes)
   );

endmodule

//--- hdl/mac_loopback_settings.svh
`ifndef MAC_LOOPBACK_SETTINGS_SVH
`define MAC_LOOPBACK_SETTINGS_SVH

// Stream widths
`define XGMAC_DATA_W        64
`define XGMAC_KEEP_W        8      // One enable per data byte

// Host register bus
`define XGMAC_REG_ADDR_W    11
`define XGMAC_REG_DATA_W    32

// Register map, byte offsets
`define XGMAC_REG_CTRL      11'h000  // Bit 0 swap enable, bit 1 counter clear
`define XGMAC_REG_RX_GOOD   11'h004
`define XGMAC_REG_RX_BAD    11'h008
`define XGMAC_REG_TX_FRAMES 11'h00C
`define XGMAC_REG_RX_BYTES  11'h010

`endif

//--- hdl/xgmac_address_swap.sv
`timescale 1ns/10ps

module xgmac_address_swap
   import xgmac_pkg::*;
(
   input  logic     rx_clk,
   input  logic     arst_n,
   input  logic     swap_en,    // From control register
   input  rx_beat_t rx_beat,
   input  logic     rx_tvalid,
   output logic     rx_tready,
   output tx_beat_t tx_beat,
   output logic     tx_tvalid,
   input  logic     tx_tready
);

   swap_state_t state;

   tx_beat_t hold_beat;          // Waits for the next beat of its frame
   logic     hold_valid;
   tx_beat_t out_beat;           // Drives the transmit side
   logic     out_valid;

   logic     out_free;
   logic     rx_fire;
   logic     head_second;        // Incoming beat is the second of a frame
   logic     swap_now;
   logic     move;               // Hold register advances to output
   tx_beat_t out_next;
   tx_beat_t hold_next;

   // Output slot empties this cycle or is already empty
   assign out_free  = !out_valid || tx_tready;
   assign rx_tready = !hold_valid || out_free;  // Low only when both full
   assign rx_fire   = rx_tvalid && rx_tready;

   assign head_second = (state == SWAP_HEAD) && hold_valid && !hold_beat.tlast;
   assign swap_now    = rx_fire && head_second && swap_en;

   // Held beat leaves once its successor arrives or it closes the frame
   assign move = hold_valid && out_free && (hold_beat.tlast || rx_fire);

   always_comb begin
      out_next = hold_beat;
      if (swap_now) begin
         // Bytes 0-1 from 6-7, bytes 2-5 from bytes 8-11 of next beat
         out_next.tdata[15:0]  = hold_beat.tdata[63:48];
         out_next.tdata[47:16] = rx_beat.tdata[31:0];
         out_next.tdata[63:48] = hold_beat.tdata[15:0];  // Old dest bytes 0-1
      end
   end

   always_comb begin
      hold_next.tdata = rx_beat.tdata;
      hold_next.tkeep = rx_beat.tkeep;
      hold_next.tlast = rx_beat.tlast;                 // tuser dropped here
      if (swap_now)
         hold_next.tdata[31:0] = hold_beat.tdata[47:16]; // Old dest bytes 2-5
   end

   // Frame position, tracked on the receive side
   always_ff @(posedge rx_clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= SWAP_HEAD;
      end else if (rx_fire) begin
         if (rx_beat.tlast)
            state <= SWAP_HEAD;
         else if (head_second)
            state <= SWAP_BODY;
      end
   end

   always_ff @(posedge rx_clk or negedge arst_n) begin
      if (!arst_n) begin
         hold_valid <= 1'b0;
         out_valid  <= 1'b0;
      end else begin
         if (rx_fire)
            hold_valid <= 1'b1;
         else if (move)
            hold_valid <= 1'b0;
         if (move)
            out_valid <= 1'b1;
         else if (tx_tready)
            out_valid <= 1'b0;    // Beat taken, nothing new
      end
   end

   // Payload only
   always_ff @(posedge rx_clk) begin
      if (rx_fire)
         hold_beat <= hold_next;
      if (move)
         out_beat <= out_next;
   end

   assign tx_beat   = out_beat;
   assign tx_tvalid = out_valid;

endmodule

//--- hdl/xgmac_frame_stats.sv
`timescale 1ns/10ps

module xgmac_frame_stats
   import xgmac_pkg::*;
(
   input  logic      rx_clk,
   input  logic      arst_n,
   input  rx_beat_t  rx_beat,
   input  logic      rx_tvalid,
   input  logic      rx_tready,
   input  tx_beat_t  tx_beat,
   input  logic      tx_tvalid,
   input  logic      tx_tready,
   input  logic      stat_clear,  // One cycle pulse from register bank
   output stat_cnt_t rx_good,
   output stat_cnt_t rx_bad,
   output stat_cnt_t tx_frames,
   output stat_cnt_t rx_bytes
);

`include "mac_loopback_settings.svh"

   logic      rx_fire;
   logic      tx_fire;
   stat_cnt_t rx_beat_bytes;

   // Population count of byte enables
   function automatic stat_cnt_t keep_count(input axis_keep_t keep);
      stat_cnt_t n;
      n = '0;
      for (int i = 0; i < `XGMAC_KEEP_W; i++)
         n = n + stat_cnt_t'(keep[i]);
      return n;
   endfunction

   assign rx_fire       = rx_tvalid && rx_tready;
   assign tx_fire       = tx_tvalid && tx_tready;
   assign rx_beat_bytes = keep_count(rx_beat.tkeep);

   always_ff @(posedge rx_clk or negedge arst_n) begin
      if (!arst_n) begin
         rx_good   <= '0;
         rx_bad    <= '0;
         tx_frames <= '0;
         rx_bytes  <= '0;
      end else if (stat_clear) begin   // Clear beats any increment
         rx_good   <= '0;
         rx_bad    <= '0;
         tx_frames <= '0;
         rx_bytes  <= '0;
      end else begin
         if (rx_fire && rx_beat.tlast) begin
            if (rx_beat.tuser)
               rx_bad <= rx_bad + 1'b1;   // Bad flag only valid on last beat
            else
               rx_good <= rx_good + 1'b1;
         end
         if (rx_fire)
            rx_bytes <= rx_bytes + rx_beat_bytes;
         if (tx_fire && tx_beat.tlast)
            tx_frames <= tx_frames + 1'b1;
      end
   end

endmodule

//--- hdl/xgmac_pkg.sv
package xgmac_pkg;

`include "mac_loopback_settings.svh"

   typedef logic [`XGMAC_DATA_W-1:0]     axis_data_t;  // One stream word
   typedef logic [`XGMAC_KEEP_W-1:0]     axis_keep_t;  // Byte enables
   typedef logic [`XGMAC_REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [`XGMAC_REG_DATA_W-1:0] reg_data_t;
   typedef logic [31:0]                  stat_cnt_t;   // Wrapping counter

   // Receive beat, tuser flags a bad frame on the last beat
   typedef struct packed {
      axis_data_t tdata;
      axis_keep_t tkeep;
      logic       tlast;
      logic       tuser;
   } rx_beat_t;

   typedef struct packed {
      axis_data_t tdata;
      axis_keep_t tkeep;
      logic       tlast;
   } tx_beat_t;

   // Host request, cs is a single cycle strobe
   typedef struct packed {
      logic      cs;
      logic      rnw;    // High for read
      reg_addr_t addr;
      reg_data_t wdata;
   } reg_req_t;

   typedef struct packed {
      reg_data_t rdata;
      logic      rdack;
      logic      wrack;
      logic      error;  // Unmapped address
   } reg_rsp_t;

   typedef enum logic {
      SWAP_HEAD,  // At frame start, first beat not yet paired
      SWAP_BODY   // Addresses done, passing the rest
   } swap_state_t;

endpackage

//--- hdl/xgmac_reg_bank.sv
`timescale 1ns/10ps

module xgmac_reg_bank
   import xgmac_pkg::*;
(
   input  logic      rx_clk,
   input  logic      arst_n,
   input  reg_req_t  reg_req,
   output reg_rsp_t  reg_rsp,
   output logic      swap_en,
   output logic      stat_clear,
   input  stat_cnt_t rx_good,
   input  stat_cnt_t rx_bad,
   input  stat_cnt_t tx_frames,
   input  stat_cnt_t rx_bytes
);

`include "mac_loopback_settings.svh"

   logic      addr_hit;     // Address is in the map
   reg_data_t rd_mux;
   logic      ctrl_wr;

   reg_data_t rdata_q;
   logic      rdack_q;
   logic      wrack_q;
   logic      error_q;

   // Read decode
   always_comb begin
      addr_hit = 1'b1;
      case (reg_req.addr)
         `XGMAC_REG_CTRL:      rd_mux = reg_data_t'(swap_en);  // Clear bit reads 0
         `XGMAC_REG_RX_GOOD:   rd_mux = rx_good;
         `XGMAC_REG_RX_BAD:    rd_mux = rx_bad;
         `XGMAC_REG_TX_FRAMES: rd_mux = tx_frames;
         `XGMAC_REG_RX_BYTES:  rd_mux = rx_bytes;
         default: begin
            addr_hit = 1'b0;
            rd_mux   = '0;
         end
      endcase
   end

   assign ctrl_wr = reg_req.cs && !reg_req.rnw && (reg_req.addr == `XGMAC_REG_CTRL);

   // Control register and handshake
   always_ff @(posedge rx_clk or negedge arst_n) begin
      if (!arst_n) begin
         swap_en    <= 1'b1;    // Swap on out of reset
         stat_clear <= 1'b0;
         rdack_q    <= 1'b0;
         wrack_q    <= 1'b0;
         error_q    <= 1'b0;
      end else begin
         rdack_q    <= reg_req.cs && reg_req.rnw;
         wrack_q    <= reg_req.cs && !reg_req.rnw;
         error_q    <= reg_req.cs && !addr_hit;
         stat_clear <= ctrl_wr && reg_req.wdata[1];   // Write only action
         if (ctrl_wr)
            swap_en <= reg_req.wdata[0];
      end
   end

   // Read data lines up with rdack
   always_ff @(posedge rx_clk) begin
      if (reg_req.cs)
         rdata_q <= reg_req.rnw ? rd_mux : '0;
   end

   assign reg_rsp = '{rdata: rdata_q, rdack: rdack_q, wrack: wrack_q, error: error_q};

endmodule

//--- mac_loopback.f
+incdir+hdl
hdl/xgmac_pkg.sv
hdl/xgmac_address_swap.sv
hdl/xgmac_frame_stats.sv
hdl/xgmac_reg_bank.sv
hdl/mac_loopback.sv
verification/tb_mac_loopback.sv

//--- verification/tb_mac_loopback.sv
`timescale 1ns/10ps

`include "mac_loopback_settings.svh"

module tb_mac_loopback
   import xgmac_pkg::*;
();

   localparam int RESET_CYCLES = 16;
   localparam int MAX_LEN      = 6;
   localparam int FRAMES       = 40;               // All three phases
   localparam int MAX_BEATS    = FRAMES * MAX_LEN;
   localparam int REG_OPS      = 24;
   localparam int IDLE_LIMIT   = 8;                // Quiet transmit cycles that end a drain
   // Beat, gap and stall per beat, three cycles per register access
   localparam int CYCLE_LIMIT  = 2 * (3 * MAX_BEATS + 3 * REG_OPS) + RESET_CYCLES + 200;

   logic        rx_clk = 1'b0;
   logic        arst_n;
   rx_beat_t    rx_beat;
   logic        rx_tvalid;
   logic        rx_tready;
   tx_beat_t    tx_beat;
   logic        tx_tvalid;
   logic        tx_tready;
   reg_req_t    reg_req;
   reg_rsp_t    reg_rsp;

   logic [15:0] stim_lfsr  = 16'd8;
   logic [15:0] stall_lfsr = 16'd8;               // Own copy for back-pressure
   tx_beat_t    exp_q [$];                        // Expected transmit beats
   logic        swap_model = 1'b1;
   stat_cnt_t   m_good;
   stat_cnt_t   m_bad;
   stat_cnt_t   m_tx;
   stat_cnt_t   m_bytes;
   int          errors = 0;
   int          cycles = 0;

   always #2 rx_clk = ~rx_clk;                    // 4 ns period

   mac_loopback u_dut (.*);

   // 16-bit Fibonacci LFSR, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [63:0] take_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         stim_lfsr = lfsr_next(stim_lfsr);        // One step per bit
         v = {v[62:0], stim_lfsr[0]};
      end
      return v;
   endfunction

   // Back-pressure, roughly one cycle in four
   always @(posedge rx_clk) begin
      #1;
      stall_lfsr = lfsr_next(stall_lfsr);
      stall_lfsr = lfsr_next(stall_lfsr);
      tx_tready  = stall_lfsr[1] | stall_lfsr[0];
   end

   // Held beat must not change while stalled
   assert property (@(posedge rx_clk) disable iff (!arst_n)
      tx_tvalid && !tx_tready |=> tx_tvalid && $stable(tx_beat))
   else begin
      errors++;
      $display("CHECK FAILED tx_beat under stall: now %h valid %h", tx_beat, tx_tvalid);
   end

   // Negedge sees the handshake that completes on the next rising edge
   always @(negedge rx_clk) begin : tx_monitor
      tx_beat_t expected_beat;
      if (arst_n && tx_tvalid && tx_tready) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("Transmit beat %h arrived with no beat expected", tx_beat);
         end else begin
            expected_beat = exp_q.pop_front();
            assert (tx_beat === expected_beat) else begin
               errors++;
               $display("CHECK FAILED tx_beat: got %h expected %h", tx_beat, expected_beat);
            end
         end
      end
   end

   always @(posedge rx_clk) begin
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles, the stream or register bus is stuck", cycles);
         $display("Error count: %0d", errors);
         $display("Errors found");
         $finish;
      end
   end

   // Random frame, its expected echo and the model counts
   task automatic send_frame();
      int         len;
      logic       bad;
      logic       acc;
      logic [7:0] tmp;
      axis_data_t data [MAX_LEN];
      axis_keep_t keep [MAX_LEN];
      logic [7:0] fb [MAX_LEN*8];                 // Frame as a byte array
      len = int'(take_bits(3) % 64'd6) + 1;
      bad = (take_bits(2) == 64'd0);
      for (int b = 0; b < len; b++) begin
         data[b] = take_bits(64);
         keep[b] = 8'hFF;
      end
      keep[len-1] = 8'hFF >> take_bits(3);        // 1 to 8 bytes in last beat
      if (bad)
         m_bad = m_bad + 1;
      else
         m_good = m_good + 1;
      m_tx = m_tx + 1;                            // Bad frames still go out
      for (int b = 0; b < len; b++)
         m_bytes = m_bytes + stat_cnt_t'($countones(keep[b]));
      for (int i = 0; i < len * 8; i++)
         fb[i] = data[i / 8][(i % 8) * 8 +: 8];
      if (swap_model && len > 1) begin
         for (int i = 0; i < 6; i++) begin       // Destination and source MAC
            tmp     = fb[i];
            fb[i]   = fb[i+6];
            fb[i+6] = tmp;
         end
      end
      for (int b = 0; b < len; b++) begin
         tx_beat_t e;
         for (int k = 0; k < 8; k++)
            e.tdata[k*8 +: 8] = fb[b*8 + k];
         e.tkeep = keep[b];
         e.tlast = (b == len - 1);
         exp_q.push_back(e);
      end
      for (int b = 0; b < len; b++) begin
         if (take_bits(2) == 64'd0) begin
            rx_tvalid = 1'b0;                     // Idle cycle inside the frame
            @(posedge rx_clk);
            #1;
         end
         rx_beat = '{tdata: data[b], tkeep: keep[b], tlast: (b == len - 1),
                     tuser: (bad && b == len - 1)};
         rx_tvalid = 1'b1;
         do begin
            @(negedge rx_clk);
            acc = rx_tready;
            @(posedge rx_clk);
         end while (!acc);
         #1;
      end
      rx_tvalid = 1'b0;
   endtask

   // Ends when the queue empties or the transmit side has gone quiet
   task automatic drain();
      int idle;
      idle = 0;
      while ((exp_q.size() != 0 || tx_tvalid) && idle < IDLE_LIMIT) begin
         @(posedge rx_clk);
         #1;
         if (tx_tvalid)
            idle = 0;
         else
            idle++;
      end
   endtask

   // One access, acknowledge checked one cycle after cs and gone after that
   task automatic reg_access(input logic rnw, input reg_addr_t addr, input reg_data_t wdata,
                             input logic exp_err, input reg_data_t exp_rdata);
      reg_req = '{cs: 1'b1, rnw: rnw, addr: addr, wdata: wdata};
      assert (!reg_rsp.rdack && !reg_rsp.wrack) else begin
         errors++;
         $display("Acknowledge seen before the request to %h", addr);
      end
      @(posedge rx_clk);
      #1;
      reg_req.cs = 1'b0;
      assert (reg_rsp.rdack == rnw && reg_rsp.wrack == !rnw) else begin
         errors++;
         $display("CHECK FAILED reg_rsp.rdack/wrack at %h: got %h/%h", addr,
                  reg_rsp.rdack, reg_rsp.wrack);
      end
      assert (reg_rsp.error == exp_err) else begin
         errors++;
         $display("CHECK FAILED reg_rsp.error at %h: got %h expected %h", addr,
                  reg_rsp.error, exp_err);
      end
      if (rnw) begin
         assert (reg_rsp.rdata == exp_rdata) else begin
            errors++;
            $display("CHECK FAILED reg_rsp.rdata at %h: got %h expected %h", addr,
                     reg_rsp.rdata, exp_rdata);
         end
      end
      @(posedge rx_clk);
      #1;
      assert (!reg_rsp.rdack && !reg_rsp.wrack && !reg_rsp.error) else begin
         errors++;
         $display("Acknowledge to %h lasted more than one cycle", addr);
      end
   endtask

   task automatic reg_read(input reg_addr_t addr, input reg_data_t expected);
      reg_access(1'b1, addr, '0, 1'b0, expected);
   endtask

   task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
      reg_access(1'b0, addr, data, 1'b0, '0);
   endtask

   task automatic check_counters();
      reg_read(`XGMAC_REG_RX_GOOD, m_good);
      reg_read(`XGMAC_REG_RX_BAD, m_bad);
      reg_read(`XGMAC_REG_TX_FRAMES, m_tx);
      reg_read(`XGMAC_REG_RX_BYTES, m_bytes);
   endtask

   initial begin
      arst_n    = 1'b0;
      rx_beat   = '0;
      rx_tvalid = 1'b0;
      tx_tready = 1'b0;
      reg_req   = '0;
      m_good    = '0;
      m_bad     = '0;
      m_tx      = '0;
      m_bytes   = '0;
      repeat (RESET_CYCLES / 2) @(posedge rx_clk);
      assert (!tx_tvalid && !reg_rsp.rdack && !reg_rsp.wrack && !reg_rsp.error) else begin
         errors++;
         $display("Outputs not idle during reset");
      end
      repeat (RESET_CYCLES / 2) @(posedge rx_clk);
      #1;
      arst_n = 1'b1;
      assert (!tx_tvalid && rx_tready && !reg_rsp.rdack && !reg_rsp.wrack
              && !reg_rsp.error) else begin
         errors++;
         $display("Outputs not idle right after reset");
      end
      reg_read(`XGMAC_REG_CTRL, 32'd1);           // Swap on out of reset
      repeat (24) send_frame();
      drain();
      check_counters();
      reg_write(`XGMAC_REG_CTRL, 32'd0);          // Swap off
      swap_model = 1'b0;
      reg_read(`XGMAC_REG_CTRL, 32'd0);
      repeat (12) send_frame();
      drain();
      check_counters();
      reg_write(`XGMAC_REG_CTRL, 32'd3);          // Clear and swap back on
      swap_model = 1'b1;
      m_good     = '0;
      m_bad      = '0;
      m_tx       = '0;
      m_bytes    = '0;
      check_counters();
      reg_read(`XGMAC_REG_CTRL, 32'd1);           // Clear bit reads back 0
      reg_access(1'b1, 11'h014, '0, 1'b1, '0);    // Just past the map
      reg_access(1'b0, 11'h7FC, 32'hFFFF_FFFF, 1'b1, '0);
      repeat (4) send_frame();
      drain();
      check_counters();
      assert (exp_q.size() == 0) else begin
         errors++;
         $display("%0d expected beats never came out", exp_q.size());
      end
      $display("Error count: %0d", errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule
